/* all.f */
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/mips_control.sv
hdl/mips_regfile.sv
hdl/mips_alu.sv
hdl/mips_shifter.sv
hdl/mips_writeback.sv
hdl/mips_top.sv
dv/mips_sva.sv
dv/mips_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mips_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

/* dv/mips_tb.sv */
`timescale 1ns/1ps

module mips_tb
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 10;
    localparam int k_wb         = 0;
    localparam int k_ovf        = 1;
    localparam int k_none       = 2;

    logic              clk;
    logic              rst;
    logic              ins_valid;
    logic [data_w-1:0] ins;
    logic              wb_valid;
    wb_t               wb;
    logic              ovf;

    logic [data_w-1:0] model_regs [num_regs];
    logic [data_w-1:0] tbl_ins [$];
    logic [data_w-1:0] tbl_busy [$];
    int                tbl_kind [$];
    int                seed = 9869;
    int                errors = 0;
    int                checks = 0;
    bit                table_ready = 1'b0;

    mips_top mips_top_inst (
        .clk       (clk),
        .rst       (rst),
        .ins_valid (ins_valid),
        .ins       (ins),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .ovf       (ovf)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [15:0] rand_half();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic [data_w-1:0] r_word(logic [5:0] fn, int rs, int rt, int rd, int sh);
        return {op_special, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [data_w-1:0] i_word(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // reference behavior of one instruction on the register model
    function automatic wb_t model_exec(logic [data_w-1:0] w);
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] sx;
        logic [data_w-1:0] zx;
        logic [4:0]        sh;
        wb_t               res;
        a        = model_regs[w[25:21]];
        b        = model_regs[w[20:16]];
        sx       = {{16{w[15]}}, w[15:0]};
        zx       = {16'h0000, w[15:0]};
        sh       = w[10:6];
        res.addr = w[15:11];
        res.data = '0;
        if (w[31:26] == op_special) begin
            case (w[5:0])
                fn_add, fn_addu: res.data = a + b;
                fn_sub, fn_subu: res.data = a - b;
                fn_slt:  res.data = {31'b0, $signed(a) < $signed(b)};
                fn_sltu: res.data = {31'b0, a < b};
                fn_and:  res.data = a & b;
                fn_or:   res.data = a | b;
                fn_xor:  res.data = a ^ b;
                fn_nor:  res.data = ~(a | b);
                fn_sll:  res.data = b << sh;
                fn_srl:  res.data = b >> sh;
                fn_sra:  res.data = $signed(b) >>> sh;
                fn_sllv: res.data = b << a[4:0];
                fn_srlv: res.data = b >> a[4:0];
                fn_srav: res.data = $signed(b) >>> a[4:0];
                default: res.data = '0;
            endcase
        end else begin
            res.addr = w[20:16];
            case (w[31:26])
                op_addi, op_addiu: res.data = a + sx;
                op_slti:  res.data = {31'b0, $signed(a) < $signed(sx)};
                op_sltiu: res.data = {31'b0, a < sx};
                op_andi:  res.data = a & zx;
                op_ori:   res.data = a | zx;
                op_xori:  res.data = a ^ zx;
                op_lui:   res.data = {w[15:0], 16'h0000};
                default:  res.data = '0;
            endcase
        end
        return res;
    endfunction

    task automatic add_entry(logic [data_w-1:0] w, int kind, logic [data_w-1:0] busy_w = '0);
        tbl_ins.push_back(w);
        tbl_kind.push_back(kind);
        tbl_busy.push_back(busy_w);
    endtask

    task automatic load_reg(int r, logic [data_w-1:0] v);
        add_entry(i_word(op_lui, 0, r, v[31:16]), k_wb);
        add_entry(i_word(op_ori, r, r, v[15:0]), k_wb);
    endtask

    task automatic build_table();
        logic [5:0]  fns [8];
        logic [5:0]  ifns [7];
        logic [15:0] hi;
        logic [15:0] lo;
        int          r;
        for (r = 1; r < 4; r++) begin
            add_entry(r_word(fn_addu, 0, r, 10, 0), k_wb);
        end
        for (r = 1; r <= 5; r++) begin
            hi = rand_half();
            lo = rand_half();
            // r1 and r2 small and positive, r5 negative
            if (r <= 2) begin
                hi = hi & 16'h3fff;
            end
            if (r == 5) begin
                hi = hi | 16'h8000;
            end
            load_reg(r, {hi, lo});
        end
        load_reg(6, 32'h7fff_ffff);
        lo = rand_half();
        load_reg(7, {16'h8000, lo});
        fns = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
        foreach (fns[i]) begin
            add_entry(r_word(fns[i], 3, 4, 11 + i, 0), k_wb);
        end
        add_entry(r_word(fn_add, 1, 2, 19, 0), k_wb);
        add_entry(r_word(fn_sub, 1, 2, 20, 0), k_wb);
        add_entry(r_word(fn_slt, 5, 1, 21, 0), k_wb);
        add_entry(r_word(fn_sltu, 5, 1, 22, 0), k_wb);
        // immediates with bit 15 set, then clear
        ifns = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori};
        foreach (ifns[i]) begin
            add_entry(i_word(ifns[i], 1, 20 + i, rand_half() | 16'h8000), k_wb);
        end
        foreach (ifns[i]) begin
            add_entry(i_word(ifns[i], 5, 20 + i, rand_half() & 16'h7fff), k_wb);
        end
        for (r = 0; r < 2; r++) begin
            add_entry(r_word(fn_sll, 0, 1 + 4 * r, 27, rand_half()), k_wb);
            add_entry(r_word(fn_srl, 0, 1 + 4 * r, 28, rand_half()), k_wb);
            add_entry(r_word(fn_sra, 0, 1 + 4 * r, 29, rand_half()), k_wb);
            add_entry(r_word(fn_sllv, 3, 4 + r, 27, 0), k_wb);
            add_entry(r_word(fn_srlv, 3, 4 + r, 28, 0), k_wb);
            add_entry(r_word(fn_srav, 3, 4 + r, 29, 0), k_wb);
        end
        // traps into r11, which must keep its value
        add_entry(r_word(fn_add, 6, 6, 11, 0), k_ovf);
        add_entry(r_word(fn_sub, 7, 6, 11, 0), k_ovf);
        add_entry(i_word(op_addi, 6, 11, 16'h0001), k_ovf);
        add_entry(r_word(fn_addu, 11, 0, 12, 0), k_wb);
        add_entry(r_word(fn_addu, 6, 6, 13, 0), k_wb);
        add_entry(r_word(fn_subu, 7, 6, 13, 0), k_wb);
        add_entry(i_word(op_addiu, 6, 13, 16'h0001), k_wb);
        hi = rand_half();
        add_entry({6'h3f, hi, 10'h000}, k_none);
        add_entry(r_word(fn_add, 1, 2, 14, 3), k_none);
        add_entry(r_word(fn_addu, 1, 2, 0, 0), k_none);
        add_entry(i_word(op_lui, 0, 0, 16'h1234), k_none);
        // second strobe arrives during decode
        add_entry(r_word(fn_addu, 1, 2, 14, 0), k_wb, i_word(op_ori, 0, 15, 16'h5a5a));
        add_entry(r_word(fn_addu, 15, 0, 16, 0), k_wb);
        add_entry(r_word(fn_addu, 14, 0, 17, 0), k_wb);
    endtask

    task automatic report_value(string sig, int idx, logic [31:0] exp, logic [31:0] got);
        errors++;
        $display("ERR entry %0d %s exp %h got %h", idx, sig, exp, got);
    endtask

    task automatic check_silent(int idx);
        checks++;
        if (wb_valid !== 1'b0) begin
            report_value("wb_valid", idx, 0, wb_valid);
        end
        if (ovf !== 1'b0) begin
            report_value("ovf", idx, 0, ovf);
        end
    endtask

    task automatic check_result(int idx, wb_t exp);
        int kind;
        kind = tbl_kind[idx];
        checks++;
        if (wb_valid !== (kind == k_wb)) begin
            report_value("wb_valid", idx, kind == k_wb, wb_valid);
        end
        if (ovf !== (kind == k_ovf)) begin
            report_value("ovf", idx, kind == k_ovf, ovf);
        end
        if (kind == k_wb) begin
            if (wb.addr !== exp.addr) begin
                report_value("wb.addr", idx, exp.addr, wb.addr);
            end
            if (wb.data !== exp.data) begin
                report_value("wb.data", idx, exp.data, wb.data);
            end
            model_regs[exp.addr] = exp.data;
        end
    endtask

    task automatic run_entry(int idx);
        logic [data_w-1:0] w;
        wb_t               exp;
        int                wait_cycles;
        int                k;
        w   = tbl_ins[idx];
        exp = model_exec(w);
        // lui has no execute cycle
        wait_cycles = (w[31:26] == op_lui) ? 2 : 3;
        ins_valid   = 1'b1;
        ins         = w;
        for (k = 1; k <= wait_cycles; k++) begin
            @(negedge clk);
            ins_valid = 1'b0;
            if (k == 1 && tbl_busy[idx] != '0) begin
                ins_valid = 1'b1;
                ins       = tbl_busy[idx];
            end
            if (k < wait_cycles) begin
                check_silent(idx);
            end
        end
        check_result(idx, exp);
        @(negedge clk);
        check_silent(idx);
    endtask

    initial begin
        int i;
        rst       = 1'b1;
        ins_valid = 1'b0;
        ins       = '0;
        for (i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_silent(-1);
        end
        for (i = 0; i < tbl_ins.size(); i++) begin
            run_entry(i);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = (tbl_ins.size() * 6 + reset_cycles + 4) * clk_period;
        #(limit);
        $display("timeout: instruction table did not finish within %0d ns", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* dv/mips_sva.sv */
`timescale 1ns/1ps

module mips_sva
    import mips_ctrl_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic wb_valid,
    input wb_t  wb,
    input logic ovf
);

    // a trap replaces the write
    wb_ovf_excl: assert property (@(posedge clk) disable iff (rst) !(wb_valid && ovf))
        else $error("wb_valid and ovf high in the same cycle");

    single_cycle: assert property (@(posedge clk) disable iff (rst)
        (wb_valid || ovf) |=> !(wb_valid || ovf))
        else $error("write-back port active two cycles in a row");

    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb.addr != '0)
        else $error("wb_valid raised with wb.addr zero");

endmodule

bind mips_top mips_sva mips_sva_inst (
    .clk      (clk),
    .rst      (rst),
    .wb_valid (wb_valid),
    .wb       (wb),
    .ovf      (ovf)
);

/* hdl/mips_top.sv */
`timescale 1ns/1ps

module mips_top
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              ins_valid,
    input  logic [data_w-1:0] ins,
    output logic              wb_valid,
    output wb_t               wb,
    output logic              ovf
);

    ins_fields_t       fields;
    ctrl_t             ctrl;
    logic              exe_en;
    logic              wb_en;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_result;
    logic              alu_ovf;
    logic [data_w-1:0] shift_result;

    mips_control mips_control_inst (
        .clk       (clk),
        .rst       (rst),
        .ins_valid (ins_valid),
        .ins       (ins),
        .fields    (fields),
        .ctrl      (ctrl),
        .exe_en    (exe_en),
        .wb_en     (wb_en)
    );

    mips_regfile mips_regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .rs       (fields.rs),
        .rt       (fields.rt),
        .wb_valid (wb_valid),
        .wb       (wb),
        .op_a     (op_a),
        .op_b     (op_b)
    );

    mips_alu mips_alu_inst (
        .clk        (clk),
        .rst        (rst),
        .op_a       (op_a),
        .op_b       (op_b),
        .imm16      (fields.imm16),
        .ctrl       (ctrl),
        .exe_en     (exe_en),
        .alu_result (alu_result),
        .alu_ovf    (alu_ovf)
    );

    mips_shifter mips_shifter_inst (
        .clk          (clk),
        .rst          (rst),
        .op_a         (op_a),
        .op_b         (op_b),
        .shamt        (fields.shamt),
        .ctrl         (ctrl),
        .exe_en       (exe_en),
        .shift_result (shift_result)
    );

    mips_writeback mips_writeback_inst (
        .wb_en        (wb_en),
        .ctrl         (ctrl),
        .fields       (fields),
        .alu_result   (alu_result),
        .alu_ovf      (alu_ovf),
        .shift_result (shift_result),
        .wb           (wb),
        .wb_valid     (wb_valid),
        .ovf          (ovf)
    );

endmodule

/* hdl/mips_writeback.sv */
`timescale 1ns/1ps

module mips_writeback
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic              wb_en,
    input  ctrl_t             ctrl,
    input  ins_fields_t       fields,
    input  logic [data_w-1:0] alu_result,
    input  logic              alu_ovf,
    input  logic [data_w-1:0] shift_result,
    output wb_t               wb,
    output logic              wb_valid,
    output logic              ovf
);

    logic trap;

    always_comb begin
        case (ctrl.wb_sel)
            wb_shift: wb.data = shift_result;
            wb_lui:   wb.data = {fields.imm16, {(data_w-imm_w){1'b0}}};
            default:  wb.data = alu_result;
        endcase
    end

    assign wb.addr = ctrl.dest_rt ? fields.rt : fields.rd;

    // overflow replaces the write
    // writes to r0 are dropped
    assign trap     = ctrl.ovf_check && alu_ovf;
    assign ovf      = wb_en && trap;
    assign wb_valid = wb_en && !trap && (wb.addr != '0);

endmodule

/* hdl/mips_shifter.sv */
`timescale 1ns/1ps

module mips_shifter
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [data_w-1:0]     op_a,
    input  logic [data_w-1:0]     op_b,
    input  logic [reg_addr_w-1:0] shamt,
    input  ctrl_t                 ctrl,
    input  logic                  exe_en,
    output logic [data_w-1:0]     shift_result
);

    logic [reg_addr_w-1:0] amt;
    logic [data_w-1:0]     res;

    // variable forms use the low bits of rs
    assign amt = ctrl.shift_var ? op_a[reg_addr_w-1:0] : shamt;

    always_comb begin
        case (ctrl.shift_op)
            sh_srl:  res = op_b >> amt;
            sh_sra:  res = $unsigned($signed(op_b) >>> amt);
            default: res = op_b << amt;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_result <= '0;
        end else if (exe_en) begin
            shift_result <= res;
        end
    end

endmodule

/* hdl/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] op_a,
    input  logic [data_w-1:0] op_b,
    input  logic [imm_w-1:0]  imm16,
    input  ctrl_t             ctrl,
    input  logic              exe_en,
    output logic [data_w-1:0] alu_result,
    output logic              alu_ovf
);

    logic [data_w-1:0] imm_ext;
    logic [data_w-1:0] opnd_b;
    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic [data_w-1:0] res;
    logic              ovf;

    assign imm_ext = ctrl.sign_ext ? {{(data_w-imm_w){imm16[imm_w-1]}}, imm16}
                                   : {{(data_w-imm_w){1'b0}}, imm16};
    assign opnd_b  = ctrl.use_imm ? imm_ext : op_b;
    assign sum     = op_a + opnd_b;
    assign diff    = op_a - opnd_b;

    always_comb begin
        res = '0;
        ovf = 1'b0;
        case (ctrl.alu_op)
            alu_add: begin
                res = sum;
                // same-sign operands giving a result of the other sign
                ovf = (op_a[data_w-1] == opnd_b[data_w-1]) &&
                      (sum[data_w-1] != op_a[data_w-1]);
            end
            alu_sub: begin
                res = diff;
                ovf = (op_a[data_w-1] != opnd_b[data_w-1]) &&
                      (diff[data_w-1] != op_a[data_w-1]);
            end
            alu_slt:  res[0] = $signed(op_a) < $signed(opnd_b);
            alu_sltu: res[0] = op_a < opnd_b;
            alu_and:  res = op_a & opnd_b;
            alu_or:   res = op_a | opnd_b;
            alu_xor:  res = op_a ^ opnd_b;
            default:  res = ~(op_a | opnd_b);
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_result <= '0;
            alu_ovf    <= 1'b0;
        end else if (exe_en) begin
            alu_result <= res;
            alu_ovf    <= ovf;
        end
    end

endmodule

/* hdl/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] rs,
    input  logic [reg_addr_w-1:0] rt,
    input  logic                  wb_valid,
    input  wb_t                   wb,
    output logic [data_w-1:0]     op_a,
    output logic [data_w-1:0]     op_b
);

    logic [data_w-1:0] regs [num_regs];

    // register 0 is never written, so it keeps its reset value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            op_a <= '0;
            op_b <= '0;
        end else begin
            if (wb_valid && wb.addr != '0) begin
                regs[wb.addr] <= wb.data;
            end
            op_a <= regs[rs];
            op_b <= regs[rt];
        end
    end

endmodule

/* hdl/mips_control.sv */
`timescale 1ns/1ps

module mips_control
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              ins_valid,
    input  logic [data_w-1:0] ins,
    output ins_fields_t       fields,
    output ctrl_t             ctrl,
    output logic              exe_en,
    output logic              wb_en
);

    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_exec,
        st_wb
    } state_e;

    state_e                state;
    logic [data_w-1:0]     ir;
    logic [opcode_w-1:0]   opcode;
    logic [opcode_w-1:0]   funct;
    logic                  dec_ok;

    // strobes only count while idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ir <= '0;
        end else if (state == st_idle && ins_valid) begin
            ir <= ins;
        end
    end

    assign opcode       = ir[opcode_lsb +: opcode_w];
    assign funct        = ir[funct_lsb +: opcode_w];
    assign fields.rs    = ir[rs_lsb +: reg_addr_w];
    assign fields.rt    = ir[rt_lsb +: reg_addr_w];
    assign fields.rd    = ir[rd_lsb +: reg_addr_w];
    assign fields.shamt = ir[shamt_lsb +: reg_addr_w];
    assign fields.imm16 = ir[imm_w-1:0];

    always_comb begin
        ctrl   = '0;
        dec_ok = 1'b0;
        case (opcode)
            op_special: begin
                // shamt must be zero except for the fixed shifts
                dec_ok = (fields.shamt == '0);
                case (funct)
                    fn_add: begin
                        ctrl.ovf_check = 1'b1;
                    end
                    fn_addu: ctrl.alu_op = alu_add;
                    fn_sub: begin
                        ctrl.alu_op    = alu_sub;
                        ctrl.ovf_check = 1'b1;
                    end
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    fn_sltu: ctrl.alu_op = alu_sltu;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_xor:  ctrl.alu_op = alu_xor;
                    fn_nor:  ctrl.alu_op = alu_nor;
                    fn_sll, fn_srl, fn_sra: begin
                        ctrl.wb_sel = wb_shift;
                        dec_ok      = (fields.rs == '0);
                    end
                    fn_sllv, fn_srlv, fn_srav: begin
                        ctrl.wb_sel    = wb_shift;
                        ctrl.shift_var = 1'b1;
                    end
                    default: dec_ok = 1'b0;
                endcase
                if (funct == fn_srl || funct == fn_srlv) begin
                    ctrl.shift_op = sh_srl;
                end else if (funct == fn_sra || funct == fn_srav) begin
                    ctrl.shift_op = sh_sra;
                end
            end
            op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
                dec_ok         = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.dest_rt   = 1'b1;
                // logic immediates are zero extended
                ctrl.sign_ext  = (opcode < op_andi);
                ctrl.ovf_check = (opcode == op_addi);
                case (opcode)
                    op_slti:  ctrl.alu_op = alu_slt;
                    op_sltiu: ctrl.alu_op = alu_sltu;
                    op_andi:  ctrl.alu_op = alu_and;
                    op_ori:   ctrl.alu_op = alu_or;
                    op_xori:  ctrl.alu_op = alu_xor;
                    default:  ctrl.alu_op = alu_add;
                endcase
            end
            op_lui: begin
                dec_ok       = (fields.rs == '0);
                ctrl.wb_sel  = wb_lui;
                ctrl.dest_rt = 1'b1;
            end
            default: dec_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (ins_valid) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    if (!dec_ok) begin
                        state <= st_idle;
                    end else if (ctrl.wb_sel == wb_lui) begin
                        // nothing to compute for lui
                        state <= st_wb;
                    end else begin
                        state <= st_exec;
                    end
                end
                st_exec: state <= st_wb;
                default: state <= st_idle;
            endcase
        end
    end

    assign exe_en = (state == st_exec);
    assign wb_en  = (state == st_wb);

endmodule

/* hdl/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor
    } alu_op_e;

    typedef enum logic [1:0] {
        sh_sll,
        sh_srl,
        sh_sra
    } shift_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_shift,
        wb_lui
    } wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      sign_ext;
        shift_op_e shift_op;
        // amount from rs, not shamt
        logic      shift_var;
        wb_sel_e   wb_sel;
        logic      dest_rt;
        logic      ovf_check;
    } ctrl_t;

    typedef struct packed {
        logic [mips_isa_pkg::reg_addr_w-1:0] addr;
        logic [mips_isa_pkg::data_w-1:0]     data;
    } wb_t;

endpackage

/* hdl/mips_isa_pkg.sv */
package mips_isa_pkg;

    parameter int data_w     = 32;
    parameter int reg_addr_w = 5;
    parameter int num_regs   = 32;
    parameter int imm_w      = 16;
    parameter int opcode_w   = 6;

    // field positions in the instruction word
    parameter int opcode_lsb = 26;
    parameter int rs_lsb     = 21;
    parameter int rt_lsb     = 16;
    parameter int rd_lsb     = 11;
    parameter int shamt_lsb  = 6;
    parameter int funct_lsb  = 0;

    // opcodes
    parameter logic [opcode_w-1:0] op_special = 6'h00;
    parameter logic [opcode_w-1:0] op_addi    = 6'h08;
    parameter logic [opcode_w-1:0] op_addiu   = 6'h09;
    parameter logic [opcode_w-1:0] op_slti    = 6'h0a;
    parameter logic [opcode_w-1:0] op_sltiu   = 6'h0b;
    parameter logic [opcode_w-1:0] op_andi    = 6'h0c;
    parameter logic [opcode_w-1:0] op_ori     = 6'h0d;
    parameter logic [opcode_w-1:0] op_xori    = 6'h0e;
    parameter logic [opcode_w-1:0] op_lui     = 6'h0f;

    // funct codes under op_special
    parameter logic [opcode_w-1:0] fn_sll  = 6'h00;
    parameter logic [opcode_w-1:0] fn_srl  = 6'h02;
    parameter logic [opcode_w-1:0] fn_sra  = 6'h03;
    parameter logic [opcode_w-1:0] fn_sllv = 6'h04;
    parameter logic [opcode_w-1:0] fn_srlv = 6'h06;
    parameter logic [opcode_w-1:0] fn_srav = 6'h07;
    parameter logic [opcode_w-1:0] fn_add  = 6'h20;
    parameter logic [opcode_w-1:0] fn_addu = 6'h21;
    parameter logic [opcode_w-1:0] fn_sub  = 6'h22;
    parameter logic [opcode_w-1:0] fn_subu = 6'h23;
    parameter logic [opcode_w-1:0] fn_and  = 6'h24;
    parameter logic [opcode_w-1:0] fn_or   = 6'h25;
    parameter logic [opcode_w-1:0] fn_xor  = 6'h26;
    parameter logic [opcode_w-1:0] fn_nor  = 6'h27;
    parameter logic [opcode_w-1:0] fn_slt  = 6'h2a;
    parameter logic [opcode_w-1:0] fn_sltu = 6'h2b;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] shamt;
        logic [imm_w-1:0]      imm16;
    } ins_fields_t;

endpackage
